// File: verilog/lane_pkg.sv
package lane_pkg;

	////////////////////////////////////////
	// Array geometry
	////////////////////////////////////////
	localparam int NUM_LANES	= 4;
	localparam int NUM_REGS		= 16;

	localparam int DATA_W		= 32;
	localparam int REG_IDX_W	= $clog2(NUM_REGS);
	localparam int LANE_IDX_W	= $clog2(NUM_LANES);

	////////////////////////////////////////
	// Data and index types
	////////////////////////////////////////
	typedef logic [DATA_W-1:0]		data_t;		// One lane word
	typedef logic [REG_IDX_W-1:0]	reg_idx_t;	// Register number
	typedef logic [LANE_IDX_W-1:0]	lane_idx_t;	// Lane number

	// Lane bus, one word per lane
	typedef data_t [NUM_LANES-1:0]	lane_t;

	typedef logic [NUM_LANES-1:0]	lane_mask_t;	// One bit per lane

	// Bit 4 picks the lane bus, 3:0 is the lane offset,
	// 1:0 alone picks the local source
	typedef logic [4:0]				path_sel_t;

	////////////////////////////////////////
	// Instruction
	////////////////////////////////////////
	typedef enum logic [2:0] {
		OP_MOV	= 3'd0,
		OP_ADD	= 3'd1,
		OP_SUB	= 3'd2,
		OP_MUL	= 3'd3,
		OP_MAD	= 3'd4,
		OP_AND	= 3'd5,
		OP_OR	= 3'd6,
		OP_XOR	= 3'd7
	} opcode_t;

	typedef struct packed {
		opcode_t	op;
		reg_idx_t	dst;			// Write-back register
		reg_idx_t	src1;
		reg_idx_t	src2;
		reg_idx_t	src3;
		path_sel_t	sel_path;		// Operand path
		path_sel_t	sel_path_wb;	// Write-back path
		data_t		scalar;			// Shared by all lanes
	} instr_t;

endpackage

// File: verilog/lane_regfile.sv
`timescale 1ns/1ps

module lane_regfile
	import lane_pkg::*;
(
	input	logic		clock,
	input	logic		rst_n,
	input	reg_idx_t	rd_idx1,
	input	reg_idx_t	rd_idx2,
	input	reg_idx_t	rd_idx3,
	output	data_t		rd_data1,
	output	data_t		rd_data2,
	output	data_t		rd_data3,
	input	logic		wr_en,
	input	reg_idx_t	wr_idx,
	input	data_t		wr_data
);

	data_t	regs [NUM_REGS];

	logic	hit1;
	logic	hit2;
	logic	hit3;

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////
	// A read in the write cycle already sees the new word,
	// so an issue on the write edge picks it up
	assign hit1		= wr_en && (wr_idx == rd_idx1);
	assign hit2		= wr_en && (wr_idx == rd_idx2);
	assign hit3		= wr_en && (wr_idx == rd_idx3);

	assign rd_data1	= hit1 ? wr_data : regs[rd_idx1];	// Port 1
	assign rd_data2	= hit2 ? wr_data : regs[rd_idx2];	// Port 2
	assign rd_data3	= hit3 ? wr_data : regs[rd_idx3];	// Port 3

endmodule

// File: verilog/lane_path_sel.sv
`timescale 1ns/1ps

module lane_path_sel
	import lane_pkg::*;
#(
	parameter int LANE_ID = 0
)(
	input	logic		req,			// Lane issues this cycle
	input	path_sel_t	sel_path,
	input	path_sel_t	sel_path_wb,
	input	data_t		scalar,
	input	lane_t		lane_data_src1,
	input	lane_t		lane_data_src2,
	input	lane_t		lane_data_src3,
	input	lane_t		lane_data_wb,
	input	data_t		src_data1,		// Own register reads
	input	data_t		src_data2,
	input	data_t		src_data3,
	input	data_t		wb_data,		// Own exec result
	output	data_t		out_src1,
	output	data_t		out_src2,
	output	data_t		out_src3,
	output	data_t		out_wb,
	output	data_t		lane_out_src1,	// Own slot on the lane bus
	output	data_t		lane_out_src2,
	output	data_t		lane_out_src3
);

	logic [4:0]	src_sum;
	logic [4:0]	wb_sum;
	lane_idx_t	src_lane;
	lane_idx_t	wb_lane;
	data_t		local_src;
	data_t		local_wb;

	////////////////////////////////////////
	// Rotation
	////////////////////////////////////////
	assign src_sum	= {1'b0, sel_path[3:0]} + 5'(LANE_ID);
	assign wb_sum	= {1'b0, sel_path_wb[3:0]} + 5'(LANE_ID);

	assign src_lane	= lane_idx_t'(src_sum % 5'(NUM_LANES));	// Wraps around the array
	assign wb_lane	= lane_idx_t'(wb_sum % 5'(NUM_LANES));

	////////////////////////////////////////
	// Local sources
	////////////////////////////////////////
	always_comb begin
		case (sel_path[1:0])
			2'd1:		local_src = src_data1;
			2'd2:		local_src = src_data2;
			2'd3:		local_src = src_data3;
			default:	local_src = scalar;
		endcase
	end

	always_comb begin
		case (sel_path_wb[1:0])
			2'd1:		local_wb = src_data1;
			2'd2:		local_wb = src_data2;
			2'd3:		local_wb = src_data3;
			default:	local_wb = wb_data;
		endcase
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////
	assign out_src1	= sel_path[4] ? lane_data_src1[src_lane] : local_src;
	assign out_src2	= sel_path[4] ? lane_data_src2[src_lane] : local_src;
	assign out_src3	= sel_path[4] ? lane_data_src3[src_lane] : local_src;
	assign out_wb	= sel_path_wb[4] ? lane_data_wb[wb_lane] : local_wb;

	assign lane_out_src1	= req ? src_data1 : '0;	// Idle lanes show zero
	assign lane_out_src2	= req ? src_data2 : '0;
	assign lane_out_src3	= req ? src_data3 : '0;

endmodule

// File: verilog/lane_exec.sv
`timescale 1ns/1ps

module lane_exec
	import lane_pkg::*;
(
	input	logic		clock,
	input	logic		rst_n,
	input	logic		valid,
	input	opcode_t	op,
	input	data_t		a,
	input	data_t		b,
	input	data_t		c,
	output	data_t		res,
	output	logic		res_valid
);

	data_t	prod;
	data_t	res_next;

	// Only the low word of the product is kept
	assign prod = a * b;

	////////////////////////////////////////
	// Arithmetic
	////////////////////////////////////////
	always_comb begin
		case (op)
			OP_MOV:		res_next = a;
			OP_ADD:		res_next = a + b;
			OP_SUB:		res_next = a - b;
			OP_MUL:		res_next = prod;
			OP_MAD:		res_next = prod + c;	// Multiply-add
			OP_AND:		res_next = a & b;
			OP_OR:		res_next = a | b;
			OP_XOR:		res_next = a ^ b;
			default:	res_next = a;
		endcase
	end

	////////////////////////////////////////
	// Result register
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= valid;
		end
	end

	// Follows the stage-1 operands every cycle,
	// so a masked-off lane still offers its result on the bus
	always_ff @(posedge clock) begin
		res <= res_next;
	end

endmodule

// File: verilog/lane_unit.sv
`timescale 1ns/1ps

module lane_unit
	import lane_pkg::*;
#(
	parameter int LANE_ID = 0
)(
	input	logic		clock,
	input	logic		rst_n,
	input	logic		issue,
	input	logic		lane_en,		// Mask bit of this lane
	input	instr_t		instr,
	input	lane_t		lane_src1,
	input	lane_t		lane_src2,
	input	lane_t		lane_src3,
	input	lane_t		lane_wb,
	output	data_t		slot_src1,		// Own reads onto the buses
	output	data_t		slot_src2,
	output	data_t		slot_src3,
	output	data_t		slot_wb,		// Own exec result onto lane_wb
	output	data_t		result,
	output	logic		result_valid
);

	logic		req;
	data_t		rd_data1, rd_data2, rd_data3;
	data_t		op_a, op_b, op_c;
	data_t		wb_value;
	logic		exec_valid;				// Stage-2 valid

	// Stage 1
	logic		s1_valid;
	opcode_t	s1_op;
	reg_idx_t	s1_dst;
	path_sel_t	s1_sel_wb;
	data_t		s1_a, s1_b, s1_c;
	data_t		s1_rd1, s1_rd2, s1_rd3;

	// Stage 2
	reg_idx_t	s2_dst;
	path_sel_t	s2_sel_wb;
	data_t		s2_rd1, s2_rd2, s2_rd3;

	assign req = issue & lane_en;

	lane_regfile u_regfile (
		.clock		(clock),
		.rst_n		(rst_n),
		.rd_idx1	(instr.src1),
		.rd_idx2	(instr.src2),
		.rd_idx3	(instr.src3),
		.rd_data1	(rd_data1),
		.rd_data2	(rd_data2),
		.rd_data3	(rd_data3),
		.wr_en		(exec_valid),
		.wr_idx		(s2_dst),
		.wr_data	(wb_value)
	);

	////////////////////////////////////////
	// Operand select at issue
	////////////////////////////////////////
	lane_path_sel #(.LANE_ID(LANE_ID)) u_sel_src (
		.req			(req),
		.sel_path		(instr.sel_path),
		.sel_path_wb	('0),
		.scalar			(instr.scalar),
		.lane_data_src1	(lane_src1),
		.lane_data_src2	(lane_src2),
		.lane_data_src3	(lane_src3),
		.lane_data_wb	('0),
		.src_data1		(rd_data1),
		.src_data2		(rd_data2),
		.src_data3		(rd_data3),
		.wb_data		('0),
		.out_src1		(op_a),
		.out_src2		(op_b),
		.out_src3		(op_c),
		.out_wb			(),
		.lane_out_src1	(slot_src1),
		.lane_out_src2	(slot_src2),
		.lane_out_src3	(slot_src3)
	);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= req;
		end
	end

	// Payload loads on every issue, masked or not
	always_ff @(posedge clock) begin
		if (issue) begin
			s1_op		<= instr.op;
			s1_dst		<= instr.dst;
			s1_sel_wb	<= instr.sel_path_wb;
			s1_a		<= op_a;
			s1_b		<= op_b;
			s1_c		<= op_c;
			s1_rd1		<= rd_data1;	// Carried for write-back select
			s1_rd2		<= rd_data2;
			s1_rd3		<= rd_data3;
		end
	end

	lane_exec u_exec (
		.clock		(clock),
		.rst_n		(rst_n),
		.valid		(s1_valid),
		.op			(s1_op),
		.a			(s1_a),
		.b			(s1_b),
		.c			(s1_c),
		.res		(slot_wb),
		.res_valid	(exec_valid)
	);

	always_ff @(posedge clock) begin
		if (s1_valid) begin
			s2_dst		<= s1_dst;
			s2_sel_wb	<= s1_sel_wb;
			s2_rd1		<= s1_rd1;
			s2_rd2		<= s1_rd2;
			s2_rd3		<= s1_rd3;
		end
	end

	////////////////////////////////////////
	// Write-back select
	////////////////////////////////////////
	lane_path_sel #(.LANE_ID(LANE_ID)) u_sel_wb (
		.req			(1'b0),
		.sel_path		('0),
		.sel_path_wb	(s2_sel_wb),
		.scalar			('0),
		.lane_data_src1	('0),
		.lane_data_src2	('0),
		.lane_data_src3	('0),
		.lane_data_wb	(lane_wb),
		.src_data1		(s2_rd1),
		.src_data2		(s2_rd2),
		.src_data3		(s2_rd3),
		.wb_data		(slot_wb),
		.out_src1		(),
		.out_src2		(),
		.out_src3		(),
		.out_wb			(wb_value),
		.lane_out_src1	(),
		.lane_out_src2	(),
		.lane_out_src3	()
	);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= exec_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (exec_valid) begin
			result <= wb_value;		// Same value as written to dst
		end
	end

endmodule

// File: verilog/lane_array.sv
`timescale 1ns/1ps

module lane_array
	import lane_pkg::*;
(
	input	logic		clock,
	input	logic		rst_n,
	input	logic		issue,			// One instruction per strobe
	input	lane_mask_t	mask,
	input	instr_t		instr,
	output	lane_mask_t	result_valid,
	output	lane_t		result
);

	////////////////////////////////////////
	// Lane buses
	////////////////////////////////////////
	lane_t	lane_src1;		// Reads at issue
	lane_t	lane_src2;
	lane_t	lane_src3;
	lane_t	lane_wb;		// Exec results

	////////////////////////////////////////
	// Lanes
	////////////////////////////////////////
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lane_unit #(
			.LANE_ID	(i)
		) u_lane (
			.clock			(clock),
			.rst_n			(rst_n),
			.issue			(issue),
			.lane_en		(mask[i]),
			.instr			(instr),		// Shared by all lanes
			.lane_src1		(lane_src1),
			.lane_src2		(lane_src2),
			.lane_src3		(lane_src3),
			.lane_wb		(lane_wb),
			.slot_src1		(lane_src1[i]),
			.slot_src2		(lane_src2[i]),
			.slot_src3		(lane_src3[i]),
			.slot_wb		(lane_wb[i]),
			.result			(result[i]),
			.result_valid	(result_valid[i])
		);
	end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS		= 4,
	parameter int RESET_CYCLES	= 16
)(
	output	logic	clock,
	output	logic	rst_n
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2.0) clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;	// Held low from time zero
		repeat (RESET_CYCLES) @(posedge clock);
		rst_n <= 1'b1;
	end

endmodule

// File: tests/tb_lane_array.sv
`timescale 1ns/1ps

module tb_lane_array
	import lane_pkg::*;
();

	localparam int MAX_EDGES = 2048;

	logic		clock;
	logic		rst_n;
	logic		issue;
	lane_mask_t	mask;
	instr_t		instr;
	lane_mask_t	result_valid;
	lane_t		result;

	data_t		model_regs [NUM_LANES][NUM_REGS];
	lane_mask_t	exp_valid [MAX_EDGES];		// Indexed by the edge that shows the result
	lane_t		exp_result [MAX_EDGES];
	lane_mask_t	wr_mask [MAX_EDGES];		// Model writes, indexed by the edge they apply at
	reg_idx_t	wr_dst [MAX_EDGES];
	lane_t		wr_val [MAX_EDGES];

	int			edge_cnt;
	int			last_due;
	int			err_cnt;
	int			check_cnt;
	logic [15:0]	lfsr;

	tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(16)) u_clock_gen (
		.clock	(clock),
		.rst_n	(rst_n)
	);

	lane_array UUT (
		.clock			(clock),
		.rst_n			(rst_n),
		.issue			(issue),
		.mask			(mask),
		.instr			(instr),
		.result_valid	(result_valid),
		.result			(result)
	);

	////////////////////////////////////////
	// Random bits and reference model
	////////////////////////////////////////
	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// x^16+x^14+x^13+x^11+1
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic data_t alu_ref(opcode_t op, data_t a, data_t b, data_t c);
		case (op)
			OP_ADD:		return a + b;
			OP_SUB:		return a - b;
			OP_MUL:		return a * b;
			OP_MAD:		return a * b + c;	// Low word only
			OP_AND:		return a & b;
			OP_OR:		return a | b;
			OP_XOR:		return a ^ b;
			default:	return a;
		endcase
	endfunction

	// Write-back value of every lane for one instruction
	function automatic lane_t lane_ref(instr_t ins, lane_mask_t m);
		lane_t	rd1, rd2, rd3;
		lane_t	bus1, bus2, bus3;
		lane_t	res, wb;
		data_t	loc;
		int		src;
		for (int l = 0; l < NUM_LANES; l++) begin
			rd1[l] = model_regs[l][ins.src1];
			rd2[l] = model_regs[l][ins.src2];
			rd3[l] = model_regs[l][ins.src3];
			bus1[l] = m[l] ? rd1[l] : '0;	// Masked-off lanes put zero on the bus
			bus2[l] = m[l] ? rd2[l] : '0;
			bus3[l] = m[l] ? rd3[l] : '0;
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			src = (l + int'(ins.sel_path[3:0])) % NUM_LANES;
			case (ins.sel_path[1:0])
				2'd1:		loc = rd1[l];
				2'd2:		loc = rd2[l];
				2'd3:		loc = rd3[l];
				default:	loc = ins.scalar;
			endcase
			if (ins.sel_path[4])
				res[l] = alu_ref(ins.op, bus1[src], bus2[src], bus3[src]);
			else
				res[l] = alu_ref(ins.op, loc, loc, loc);
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			src = (l + int'(ins.sel_path_wb[3:0])) % NUM_LANES;
			if (ins.sel_path_wb[4]) begin
				wb[l] = res[src];
			end else begin
				case (ins.sel_path_wb[1:0])
					2'd1:		wb[l] = rd1[l];
					2'd2:		wb[l] = rd2[l];
					2'd3:		wb[l] = rd3[l];
					default:	wb[l] = res[l];
				endcase
			end
		end
		return wb;
	endfunction

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////
	task automatic apply_writes(input int idx);
		for (int l = 0; l < NUM_LANES; l++) begin
			if (wr_mask[idx][l])
				model_regs[l][wr_dst[idx]] = wr_val[idx][l];
		end
	endtask

	task automatic tick();
		@(posedge clock);
		edge_cnt = edge_cnt + 1;
		apply_writes(edge_cnt);		// Visible to the issue driven now
	endtask

	task automatic idle_cycle();
		issue <= 1'b0;
		mask <= '0;
		tick();
	endtask

	task automatic issue_instr(input instr_t ins, input lane_mask_t m);
		lane_t wb;
		wb = lane_ref(ins, m);
		exp_valid[edge_cnt + 3] = m;	// Sampled next edge, shown two later
		exp_result[edge_cnt + 3] = wb;
		wr_mask[edge_cnt + 2] = m;
		wr_dst[edge_cnt + 2] = ins.dst;
		wr_val[edge_cnt + 2] = wb;
		last_due = edge_cnt + 3;
		issue <= 1'b1;
		mask <= m;
		instr <= ins;
		tick();
	endtask

	task automatic random_instr(input int idx_bits, output instr_t ins);
		logic [31:0] v;
		draw_bits(3, v);
		ins.op = opcode_t'(v[2:0]);
		draw_bits(idx_bits, v);
		ins.dst = reg_idx_t'(v);
		draw_bits(idx_bits, v);
		ins.src1 = reg_idx_t'(v);
		draw_bits(idx_bits, v);
		ins.src2 = reg_idx_t'(v);
		draw_bits(idx_bits, v);
		ins.src3 = reg_idx_t'(v);
		draw_bits(5, v);
		ins.sel_path = path_sel_t'(v);
		draw_bits(5, v);
		ins.sel_path_wb = path_sel_t'(v);
		draw_bits(32, v);
		ins.scalar = v;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_cnt = check_cnt + 1;
		if (got !== exp) begin
			err_cnt = err_cnt + 1;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Compare process
	////////////////////////////////////////
	always @(negedge clock) begin
		if (rst_n && edge_cnt < MAX_EDGES) begin
			check_value("result_valid", 32'(result_valid), 32'(exp_valid[edge_cnt]));
			for (int l = 0; l < NUM_LANES; l++) begin
				if (exp_valid[edge_cnt][l])
					check_value($sformatf("result[%0d]", l), result[l],
						exp_result[edge_cnt][l]);
			end
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		instr_t			ins;
		logic [31:0]	v;
		int				wait_cnt;
		issue = 1'b0;
		mask = '0;
		instr = '0;
		edge_cnt = 0;
		last_due = 0;
		err_cnt = 0;
		check_cnt = 0;
		lfsr = 16'd25367;
		for (int i = 0; i < MAX_EDGES; i++) begin
			exp_valid[i] = '0;
			wr_mask[i] = '0;
		end
		for (int l = 0; l < NUM_LANES; l++)
			for (int r = 0; r < NUM_REGS; r++)
				model_regs[l][r] = '0;	// Matches the register file reset

		wait_cnt = 0;
		while (rst_n !== 1'b1) begin
			tick();
			wait_cnt = wait_cnt + 1;
			if (wait_cnt > 100) begin
				$display("Timeout: reset was never released");
				$display("Simulation FAILED");
				$finish;
			end
		end

		repeat (8) idle_cycle();	// result_valid must stay low

		// Per-lane scalar loads so that lanes hold different data
		for (int r = 0; r < NUM_REGS; r++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				random_instr(4, ins);
				ins.op = OP_MOV;
				ins.dst = reg_idx_t'(r);
				ins.sel_path = '0;
				ins.sel_path_wb = '0;
				issue_instr(ins, lane_mask_t'(1 << l));
			end
		end

		// Each opcode on local operands
		for (int op = 0; op < 8; op++) begin
			repeat (4) begin
				random_instr(4, ins);
				ins.op = opcode_t'(op);
				ins.sel_path[4] = 1'b0;
				ins.sel_path_wb = '0;
				issue_instr(ins, '1);
			end
		end

		// Lane-bus operands with every offset
		for (int off = 0; off < 16; off++) begin
			repeat (2) begin
				random_instr(4, ins);
				ins.sel_path = {1'b1, 4'(off)};
				ins.sel_path_wb = '0;
				draw_bits(NUM_LANES, v);
				issue_instr(ins, lane_mask_t'(v));
			end
		end

		// Every write-back select
		for (int s = 0; s < 32; s++) begin
			random_instr(4, ins);
			ins.sel_path_wb = path_sel_t'(s);
			draw_bits(NUM_LANES, v);
			issue_instr(ins, lane_mask_t'(v) | lane_mask_t'(1 << (s % NUM_LANES)));
		end

		// Sparse masks with an empty one every fourth issue
		for (int i = 0; i < 24; i++) begin
			random_instr(4, ins);
			draw_bits(NUM_LANES, v);
			issue_instr(ins, (i % 4 == 0) ? '0 : lane_mask_t'(v));
		end

		// Back-to-back on few registers to hit read-after-write hazards
		repeat (120) begin
			random_instr(2, ins);
			draw_bits(NUM_LANES, v);
			issue_instr(ins, lane_mask_t'(v));
		end

		// Random gaps between issues
		repeat (90) begin
			draw_bits(1, v);
			if (v[0]) begin
				random_instr(2, ins);
				draw_bits(NUM_LANES, v);
				issue_instr(ins, lane_mask_t'(v));
			end else begin
				idle_cycle();
			end
		end

		wait_cnt = 0;
		while (edge_cnt <= last_due) begin
			idle_cycle();
			wait_cnt = wait_cnt + 1;
			if (wait_cnt > 20) begin
				$display("Timeout: pending results did not drain");
				$display("Simulation FAILED");
				$finish;
			end
		end
		repeat (2) idle_cycle();

		$display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: lane_array.f
verilog/lane_pkg.sv
verilog/lane_regfile.sv
verilog/lane_path_sel.sv
verilog/lane_exec.sv
verilog/lane_unit.sv
verilog/lane_array.sv
tests/tb_clock_gen.sv
tests/tb_lane_array.sv

// File: Bender.yml
package:
  name: lane_array

sources:
  - files:
      - verilog/lane_pkg.sv
      - verilog/lane_regfile.sv
      - verilog/lane_path_sel.sv
      - verilog/lane_exec.sv
      - verilog/lane_unit.sv
      - verilog/lane_array.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_lane_array.sv
